/* hw/cpu_ctl_pkg.sv */
`default_nettype none

package cpu_ctl_pkg;

    //////////////////////////////
    // Datapath dimensions
    //////////////////////////////

    // Sixteen registers, register 0 is the program counter
    localparam int NUM_REGS  = 16;
    localparam int REG_IDX_W = 4;
    // Every register drives bus A, bus B and bus C through its own tap
    localparam int BUS_TAPS  = 3;
    localparam int OUT_EN_W  = NUM_REGS * BUS_TAPS;
    localparam int CTL_W     = 11;
    localparam int IMM_W     = 16;

    // Sequencer steps, the four fetch steps are numbered by byte lane
    typedef enum logic [2:0] {
        FETCH_0 = 3'd0,
        FETCH_1 = 3'd1,
        FETCH_2 = 3'd2,
        FETCH_3 = 3'd3,
        DECODE  = 3'd4,
        EXECUTE = 3'd5
    } step_t;

    // Full opcode map, stack and memory opcodes are fetched but not executed
    typedef enum logic [3:0] {
        OP_PUSH_R   = 4'd0,
        OP_POP_R    = 4'd1,
        OP_LFUN_RR  = 4'd2,
        OP_ADD_RR   = 4'd3,
        OP_SUB_RR   = 4'd4,
        OP_ROT_RR   = 4'd5,
        OP_ROT_RC   = 4'd6,
        OP_ADD_RC   = 4'd7,
        OP_MOV_RC   = 4'd8,
        OP_PUSH_C   = 4'd9,
        OP_LFUN_CRC = 4'd10,
        OP_BEZ      = 4'd11,
        OP_BNEZ     = 4'd12,
        OP_BGEZ     = 4'd13,
        OP_LOAD     = 4'd14,
        OP_STORE    = 4'd15
    } opcode_t;

    typedef enum logic [2:0] {
        ADD      = 3'd0,
        SUB_ADDR = 3'd1,
        SUB      = 3'd2,
        ROT      = 3'd3,
        LOGIC    = 3'd4,
        BEZ      = 3'd5,
        BNEZ     = 3'd6,
        BGEZ     = 3'd7
    } alu_op_t;

    // PC on bus A into the ALU with the constant, result back into the PC
    localparam logic [CTL_W-1:0] CTL_FETCH    = 11'b00010010101;
    // Bus A and bus B into the ALU, result into the register input
    localparam logic [CTL_W-1:0] CTL_REG_REG  = 11'b00010000011;
    // Bus A and the immediate into the ALU
    localparam logic [CTL_W-1:0] CTL_REG_IMM  = 11'b00010000101;
    // Immediate straight into the register input, ALU bypassed
    localparam logic [CTL_W-1:0] CTL_LOAD_IMM = 11'b00101000000;

    // Short form carries a 16-bit constant right after the opcode byte
    typedef struct packed {
        logic [7:0]           tail;
        logic [IMM_W-1:0]     imm;
        opcode_t              opcode;
        logic [REG_IDX_W-1:0] r1;
    } insn_short_t;

    // Long form keeps both register bytes and puts the constant on top
    typedef struct packed {
        logic [IMM_W-1:0]     imm;
        logic [REG_IDX_W-1:0] r2;
        logic [REG_IDX_W-1:0] r3;
        opcode_t              opcode;
        logic [REG_IDX_W-1:0] r1;
    } insn_long_t;

    typedef union packed {
        insn_short_t short_f;
        insn_long_t  long_f;
    } insn_word_u;

    // Instruction length in bytes, taken from the upper nibble of byte 0
    function automatic logic [2:0] insn_bytes(input logic [3:0] opcode);
        if (opcode <= 4'd1) begin
            return 3'd1;
        end else if (opcode <= 4'd6) begin
            return 3'd2;
        end else if (opcode <= 4'd9) begin
            return 3'd3;
        end
        return 3'd4;
    endfunction

endpackage

`default_nettype wire

/* hw/insn_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module insn_sequencer (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic [7:0]              data_in,
    output cpu_ctl_pkg::step_t           step,
    output cpu_ctl_pkg::insn_word_u      insn
);

    import cpu_ctl_pkg::*;

    //////////////////////////////
    // Length decode
    //////////////////////////////

    // Opcode of the instruction being fetched
    logic [3:0] cur_opcode;
    // Bytes taken so far, counting the one on data_in now
    logic [2:0] byte_cnt;
    // High when this edge takes the last byte of the instruction
    logic       last_byte;
    logic       fetching;
    step_t      next_step;

    // Step codes 0 to 3 are the fetch steps
    assign fetching = (step <= FETCH_3);

    // The opcode is not yet in the register while byte 0 is on the bus,
    // so the length lookup reads it straight from data_in in that step
    assign cur_opcode = (step == FETCH_0) ? data_in[7:4] : insn.long_f.opcode;

    // Fetch step k takes byte k
    assign byte_cnt = {1'b0, step[1:0]} + 3'd1;

    assign last_byte = (byte_cnt == insn_bytes(cur_opcode));

    //////////////////////////////
    // Step sequence
    //////////////////////////////

    always_comb begin
        next_step = FETCH_0;
        case (step)
            FETCH_0, FETCH_1, FETCH_2: begin
                // Move to the next byte lane or stop when the length is reached
                if (last_byte) begin
                    next_step = DECODE;
                end else begin
                    next_step = step_t'(step + 3'd1);
                end
            end
            // A 4-byte instruction always ends in lane 3
            FETCH_3: next_step = DECODE;
            DECODE:  next_step = EXECUTE;
            // The next instruction starts straight after execute
            EXECUTE: next_step = FETCH_0;
            default: next_step = FETCH_0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step <= FETCH_0;
        end else begin
            step <= next_step;
        end
    end

    //////////////////////////////
    // Instruction register
    //////////////////////////////

    // Each fetch step writes its own byte lane, so lanes that a short
    // instruction does not fetch keep the bytes of an older instruction
    // The control decode only reads the fields of the current format
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            insn <= '0;
        end else if (fetching) begin
            insn[{step[1:0], 3'b000} +: 8] <= data_in;
        end
    end

endmodule

`default_nettype wire

/* hw/ctl_word_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module ctl_word_gen (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire cpu_ctl_pkg::step_t             step,
    input  wire cpu_ctl_pkg::insn_word_u        insn,
    output logic [cpu_ctl_pkg::NUM_REGS-1:0]    write_en,
    output logic [cpu_ctl_pkg::OUT_EN_W-1:0]    output_en,
    output cpu_ctl_pkg::alu_op_t                alu_op,
    output logic [cpu_ctl_pkg::REG_IDX_W-1:0]   alu_logic_func,
    output logic [cpu_ctl_pkg::CTL_W-1:0]       ctl_out,
    output logic [cpu_ctl_pkg::IMM_W-1:0]       immediate
);

    import cpu_ctl_pkg::*;

    // Tap offsets inside the three enable bits of one register
    localparam logic [1:0] TAP_A = 2'd0;
    localparam logic [1:0] TAP_B = 2'd1;
    localparam logic [1:0] TAP_C = 2'd2;

    // One-hot write enable for a register index
    function automatic logic [NUM_REGS-1:0] reg_sel(input logic [REG_IDX_W-1:0] idx);
        return {{(NUM_REGS-1){1'b0}}, 1'b1} << idx;
    endfunction

    // Single output enable bit for one register on one bus
    function automatic logic [OUT_EN_W-1:0] tap(input logic [REG_IDX_W-1:0] idx,
                                                input logic [1:0] offset);
        int unsigned bit_pos;
        bit_pos = idx * BUS_TAPS + offset;
        return {{(OUT_EN_W-1){1'b0}}, 1'b1} << bit_pos;
    endfunction

    //////////////////////////////
    // Field decode
    //////////////////////////////

    logic [REG_IDX_W-1:0] r1;
    logic [REG_IDX_W-1:0] r2;
    logic [REG_IDX_W-1:0] r3;
    opcode_t              opcode;
    logic [IMM_W-1:0]     imm_short;
    logic [IMM_W-1:0]     imm_long;

    // Register fields sit at the same place in both layouts
    assign r1     = insn.long_f.r1;
    assign r2     = insn.long_f.r2;
    assign r3     = insn.long_f.r3;
    assign opcode = insn.long_f.opcode;

    // 3-byte forms take the constant from bytes 1 and 2,
    // 4-byte forms from bytes 2 and 3
    assign imm_short = insn.short_f.imm;
    assign imm_long  = insn.long_f.imm;

    // The logic function code rides in r3 and goes out unregistered
    assign alu_logic_func = r3;

    //////////////////////////////
    // Control outputs
    //////////////////////////////

    // Outputs change on the falling edge so the datapath sees them
    // settled at the next rising edge
    // Anything a step does not assign keeps its previous value
    always_ff @(negedge clk or posedge reset) begin
        if (reset) begin
            write_en  <= '0;
            output_en <= '0;
            alu_op    <= ADD;
            ctl_out   <= '0;
            immediate <= '0;
        end else begin
            case (step)
                FETCH_0, FETCH_1, FETCH_2, FETCH_3: begin
                    // PC plus one goes back into the PC while the PC drives the address
                    write_en  <= reg_sel('0);
                    output_en <= tap('0, TAP_A);
                    alu_op    <= ADD;
                    ctl_out   <= CTL_FETCH;
                    immediate <= 16'd1;
                end
                EXECUTE: begin
                    case (opcode)
                        OP_LFUN_RR: begin
                            // R1 op R2 into R1
                            write_en  <= reg_sel(r1);
                            output_en <= tap(r1, TAP_A) | tap(r2, TAP_B);
                            alu_op    <= LOGIC;
                            ctl_out   <= CTL_REG_REG;
                        end
                        OP_ADD_RR, OP_SUB_RR, OP_ROT_RR: begin
                            // Destination is the high nibble of byte 1
                            write_en  <= reg_sel(r2);
                            output_en <= tap(r2, TAP_A) | tap(r3, TAP_B);
                            ctl_out   <= CTL_REG_REG;
                            if (opcode == OP_ADD_RR) begin
                                alu_op <= ADD;
                            end else if (opcode == OP_SUB_RR) begin
                                alu_op <= SUB;
                            end else begin
                                alu_op <= ROT;
                            end
                        end
                        OP_ROT_RC: begin
                            // Rotate count is the 4-bit r3 field
                            write_en  <= reg_sel(r1);
                            output_en <= tap(r1, TAP_A);
                            alu_op    <= ROT;
                            ctl_out   <= CTL_REG_IMM;
                            immediate <= {{(IMM_W-REG_IDX_W){1'b0}}, r3};
                        end
                        OP_ADD_RC: begin
                            write_en  <= reg_sel(r1);
                            output_en <= tap(r1, TAP_A);
                            alu_op    <= ADD;
                            ctl_out   <= CTL_REG_IMM;
                            immediate <= imm_short;
                        end
                        OP_MOV_RC: begin
                            // ALU is bypassed so its controls stay as they were
                            write_en  <= reg_sel(r1);
                            ctl_out   <= CTL_LOAD_IMM;
                            immediate <= imm_short;
                        end
                        OP_LFUN_CRC: begin
                            write_en  <= reg_sel(r2);
                            output_en <= tap(r2, TAP_A);
                            alu_op    <= LOGIC;
                            ctl_out   <= CTL_REG_IMM;
                            immediate <= imm_long;
                        end
                        OP_BEZ, OP_BNEZ, OP_BGEZ: begin
                            // Condition register on bus C, base on bus A,
                            // target written into the PC
                            write_en  <= reg_sel('0);
                            output_en <= tap(r2, TAP_C) | tap(r3, TAP_A);
                            ctl_out   <= CTL_REG_IMM;
                            immediate <= imm_long;
                            if (opcode == OP_BEZ) begin
                                alu_op <= BEZ;
                            end else if (opcode == OP_BNEZ) begin
                                alu_op <= BNEZ;
                            end else begin
                                alu_op <= BGEZ;
                            end
                        end
                        // Stack and memory opcodes retire like a decode step
                        default: write_en <= '0;
                    endcase
                end
                // Decode only stops the PC write
                default: write_en <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/cpu_ctl.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_ctl (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic [7:0]                     data_in,
    output logic [cpu_ctl_pkg::NUM_REGS-1:0]    write_en,
    output logic [cpu_ctl_pkg::OUT_EN_W-1:0]    output_en,
    output logic [2:0]                          alu_op,
    output logic [cpu_ctl_pkg::REG_IDX_W-1:0]   alu_logic_func,
    output logic [cpu_ctl_pkg::CTL_W-1:0]       ctl_out,
    output logic [cpu_ctl_pkg::IMM_W-1:0]       immediate
);

    import cpu_ctl_pkg::*;

    // Current step and the assembled instruction word
    step_t      step;
    insn_word_u insn;

    //////////////////////////////
    // Fetch and step control
    //////////////////////////////

    insn_sequencer i_insn_sequencer (
        .clk     (clk),
        .reset   (reset),
        .data_in (data_in),
        .step    (step),
        .insn    (insn)
    );

    //////////////////////////////
    // Control word decode
    //////////////////////////////

    // The ALU code leaves the block as a plain 3-bit vector
    ctl_word_gen i_ctl_word_gen (
        .clk            (clk),
        .reset          (reset),
        .step           (step),
        .insn           (insn),
        .write_en       (write_en),
        .output_en      (output_en),
        .alu_op         (alu_op),
        .alu_logic_func (alu_logic_func),
        .ctl_out        (ctl_out),
        .immediate      (immediate)
    );

endmodule

`default_nettype wire

/* verification/cpu_ctl_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_ctl_chk (
    input  wire logic                              clk,
    input  wire logic                              reset,
    input  wire logic [cpu_ctl_pkg::NUM_REGS-1:0]  write_en,
    input  wire logic [cpu_ctl_pkg::OUT_EN_W-1:0]  output_en,
    input  wire logic [2:0]                        alu_op,
    input  wire logic [cpu_ctl_pkg::REG_IDX_W-1:0] alu_logic_func,
    input  wire logic [cpu_ctl_pkg::CTL_W-1:0]     ctl_out,
    input  wire logic [cpu_ctl_pkg::IMM_W-1:0]     immediate
);

    import cpu_ctl_pkg::*;

    // Write enable of the PC alone, and the PC on bus A alone
    localparam logic [NUM_REGS-1:0] PC_ONLY  = {{(NUM_REGS-1){1'b0}}, 1'b1};
    localparam logic [OUT_EN_W-1:0] PC_BUS_A = {{(OUT_EN_W-1){1'b0}}, 1'b1};

    // Failed assertions so far, read by the testbench when the run ends
    int fail_count = 0;

    // A step writes one register or none at all
    write_en_single: assert property (@(posedge clk) $onehot0(write_en))
        else begin
            fail_count++;
            $error("more than one register write enable is set");
        end

    // The whole control word stays cleared while reset is held
    reset_quiet: assert property (@(posedge clk)
        reset |-> (write_en == '0 && output_en == '0 && alu_op == 3'd0 &&
                   alu_logic_func == '0 && ctl_out == '0 && immediate == '0))
        else begin
            fail_count++;
            $error("control outputs are not zero during reset");
        end

    // A fetch increments the PC, so only the PC may drive a bus
    fetch_pc_bus: assert property (@(posedge clk) disable iff (reset)
        (write_en == PC_ONLY && ctl_out == CTL_FETCH) |-> (output_en == PC_BUS_A))
        else begin
            fail_count++;
            $error("fetch word is out while a bus other than PC on bus A is enabled");
        end

endmodule

bind cpu_ctl cpu_ctl_chk i_cpu_ctl_chk (
    .clk            (clk),
    .reset          (reset),
    .write_en       (write_en),
    .output_en      (output_en),
    .alu_op         (alu_op),
    .alu_logic_func (alu_logic_func),
    .ctl_out        (ctl_out),
    .immediate      (immediate)
);

`default_nettype wire

/* verification/cpu_ctl_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_ctl_scoreboard (
    input  wire logic                              clk,
    input  wire logic                              reset,
    input  wire logic [7:0]                        data_in,
    input  wire logic [cpu_ctl_pkg::NUM_REGS-1:0]  write_en,
    input  wire logic [cpu_ctl_pkg::OUT_EN_W-1:0]  output_en,
    input  wire logic [2:0]                        alu_op,
    input  wire logic [cpu_ctl_pkg::REG_IDX_W-1:0] alu_logic_func,
    input  wire logic [cpu_ctl_pkg::CTL_W-1:0]     ctl_out,
    input  wire logic [cpu_ctl_pkg::IMM_W-1:0]     immediate,
    output int                                     error_count,
    output int                                     compare_count
);

    import cpu_ctl_pkg::*;

    localparam int PH_FETCH   = 0;
    localparam int PH_DECODE  = 1;
    localparam int PH_EXECUTE = 2;

    // Model of the instruction stream, advanced on every rising edge
    int          phase;
    int          fetch_idx;
    int          insn_len;
    logic [31:0] insn_model;

    // Expected outputs, updated on the falling edge like the DUT registers
    logic [NUM_REGS-1:0] exp_write_en;
    logic [OUT_EN_W-1:0] exp_output_en;
    logic [2:0]          exp_alu_op;
    logic [CTL_W-1:0]    exp_ctl_out;
    logic [IMM_W-1:0]    exp_immediate;
    string               test_name;

    function automatic int insn_length(input logic [3:0] op);
        case (op)
            4'd0, 4'd1:                   return 1;
            4'd2, 4'd3, 4'd4, 4'd5, 4'd6: return 2;
            4'd7, 4'd8, 4'd9:             return 3;
            default:                      return 4;
        endcase
    endfunction

    function automatic logic [NUM_REGS-1:0] reg_onehot(input logic [3:0] idx);
        return {{(NUM_REGS-1){1'b0}}, 1'b1} << idx;
    endfunction

    // Tap offset 0 is bus A, 1 is bus B and 2 is bus C
    function automatic logic [OUT_EN_W-1:0] bus_tap(input logic [3:0] idx, input int offset);
        int pos;
        pos = 3 * int'(idx) + offset;
        return {{(OUT_EN_W-1){1'b0}}, 1'b1} << pos;
    endfunction

    task automatic check_field(input string field, input logic [47:0] expected,
                               input logic [47:0] actual);
        compare_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, field, expected, actual);
        end
    endtask

    //////////////////////////////
    // Execute table
    //////////////////////////////

    task automatic execute_expect();
        logic [3:0]  op;
        logic [3:0]  r1;
        logic [3:0]  r2;
        logic [3:0]  r3;
        op = insn_model[7:4];
        r1 = insn_model[3:0];
        r3 = insn_model[11:8];
        r2 = insn_model[15:12];
        test_name = $sformatf("execute_op%0d", op);
        // Anything an opcode leaves out keeps its previous value
        case (op)
            4'd2: begin
                exp_write_en  = reg_onehot(r1);
                exp_alu_op    = LOGIC;
                exp_output_en = bus_tap(r1, 0) | bus_tap(r2, 1);
                exp_ctl_out   = CTL_REG_REG;
            end
            4'd3, 4'd4, 4'd5: begin
                exp_write_en  = reg_onehot(r2);
                exp_alu_op    = (op == 4'd3) ? ADD : (op == 4'd4) ? SUB : ROT;
                exp_output_en = bus_tap(r2, 0) | bus_tap(r3, 1);
                exp_ctl_out   = CTL_REG_REG;
            end
            4'd6, 4'd7: begin
                exp_write_en  = reg_onehot(r1);
                exp_alu_op    = (op == 4'd6) ? ROT : ADD;
                exp_output_en = bus_tap(r1, 0);
                exp_ctl_out   = CTL_REG_IMM;
                // Rotate count is r3, the add constant sits in bytes 1 and 2
                exp_immediate = (op == 4'd6) ? {12'h000, r3} : insn_model[23:8];
            end
            4'd8: begin
                exp_write_en  = reg_onehot(r1);
                exp_ctl_out   = CTL_LOAD_IMM;
                exp_immediate = insn_model[23:8];
            end
            4'd10: begin
                exp_write_en  = reg_onehot(r2);
                exp_alu_op    = LOGIC;
                exp_output_en = bus_tap(r2, 0);
                exp_ctl_out   = CTL_REG_IMM;
                exp_immediate = insn_model[31:16];
            end
            4'd11, 4'd12, 4'd13: begin
                // Branch target lands in the PC
                exp_write_en  = reg_onehot(4'd0);
                exp_alu_op    = (op == 4'd11) ? BEZ : (op == 4'd12) ? BNEZ : BGEZ;
                exp_output_en = bus_tap(r2, 2) | bus_tap(r3, 0);
                exp_ctl_out   = CTL_REG_IMM;
                exp_immediate = insn_model[31:16];
            end
            default: exp_write_en = '0;
        endcase
    endtask

    //////////////////////////////
    // Expected outputs
    //////////////////////////////

    always @(negedge clk or posedge reset) begin
        if (reset) begin
            exp_write_en  = '0;
            exp_output_en = '0;
            exp_alu_op    = '0;
            exp_ctl_out   = '0;
            exp_immediate = '0;
            test_name     = "reset";
        end else if (phase == PH_FETCH) begin
            exp_write_en  = reg_onehot(4'd0);
            exp_output_en = bus_tap(4'd0, 0);
            exp_alu_op    = ADD;
            exp_ctl_out   = CTL_FETCH;
            exp_immediate = 16'd1;
            test_name     = "fetch";
        end else if (phase == PH_DECODE) begin
            exp_write_en = '0;
            test_name    = "decode";
        end else begin
            execute_expect();
        end
    end

    //////////////////////////////
    // Compare and step the model
    //////////////////////////////

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            phase         = PH_FETCH;
            fetch_idx     = 0;
            insn_len      = 1;
            insn_model    = '0;
            error_count   = 0;
            compare_count = 0;
        end else begin
            // Outputs were set on the last falling edge, r3 comes straight from the word
            check_field("write_en", 48'(exp_write_en), 48'(write_en));
            check_field("output_en", 48'(exp_output_en), 48'(output_en));
            check_field("alu_op", 48'(exp_alu_op), 48'(alu_op));
            check_field("alu_logic_func", 48'(insn_model[11:8]), 48'(alu_logic_func));
            check_field("ctl_out", 48'(exp_ctl_out), 48'(ctl_out));
            check_field("immediate", 48'(exp_immediate), 48'(immediate));
            case (phase)
                PH_FETCH: begin
                    // Byte k goes to lane k, older lanes keep stale bytes
                    case (fetch_idx)
                        0: begin
                            insn_model[7:0] = data_in;
                            insn_len        = insn_length(data_in[7:4]);
                        end
                        1:       insn_model[15:8]  = data_in;
                        2:       insn_model[23:16] = data_in;
                        default: insn_model[31:24] = data_in;
                    endcase
                    if (fetch_idx + 1 == insn_len) begin
                        phase     = PH_DECODE;
                        fetch_idx = 0;
                    end else begin
                        fetch_idx = fetch_idx + 1;
                    end
                end
                PH_DECODE: phase = PH_EXECUTE;
                default:   phase = PH_FETCH;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verification/cpu_ctl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_ctl_tb;

    import cpu_ctl_pkg::*;

    localparam int          NUM_INSNS      = 400;
    // Longest instruction is 4 fetches plus decode and execute
    localparam int          TIMEOUT_CYCLES = NUM_INSNS * 6 + 20;
    localparam int          RESET_CYCLES   = 8;
    localparam logic [16:0] LFSR_SEED      = 17'd86454;

    logic                 clk;
    logic                 reset;
    logic [7:0]           data_in;
    logic [NUM_REGS-1:0]  write_en;
    logic [OUT_EN_W-1:0]  output_en;
    logic [2:0]           alu_op;
    logic [REG_IDX_W-1:0] alu_logic_func;
    logic [CTL_W-1:0]     ctl_out;
    logic [IMM_W-1:0]     immediate;
    int                   mismatch_count;
    int                   compare_count;
    logic [16:0]          lfsr_state;

    // Bytes per opcode, indexed by the upper nibble of byte 0
    int insn_len_table [16] = '{1, 1, 2, 2, 2, 2, 2, 3, 3, 3, 4, 4, 4, 4, 4, 4};

    // Taps at bits 17 and 14 give a maximal length sequence
    function automatic logic [16:0] lfsr_step(input logic [16:0] state);
        return {state[15:0], state[16] ^ state[13]};
    endfunction

    task automatic random_byte(output logic [7:0] value);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[6:0], lfsr_state[0]};
        end
    endtask

    cpu_ctl i_cpu_ctl (
        .clk            (clk),
        .reset          (reset),
        .data_in        (data_in),
        .write_en       (write_en),
        .output_en      (output_en),
        .alu_op         (alu_op),
        .alu_logic_func (alu_logic_func),
        .ctl_out        (ctl_out),
        .immediate      (immediate)
    );

    cpu_ctl_scoreboard i_scoreboard (
        .clk            (clk),
        .reset          (reset),
        .data_in        (data_in),
        .write_en       (write_en),
        .output_en      (output_en),
        .alu_op         (alu_op),
        .alu_logic_func (alu_logic_func),
        .ctl_out        (ctl_out),
        .immediate      (immediate),
        .error_count    (mismatch_count),
        .compare_count  (compare_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // Byte stream
    //////////////////////////////

    initial begin : stimulus
        logic [7:0] byte_val;
        int         len;
        int         assert_fails;
        reset      <= 1'b1;
        data_in    <= 8'h00;
        lfsr_state  = LFSR_SEED;
        repeat (RESET_CYCLES) @(negedge clk);
        // The edge after release is FETCH_0, so byte 0 goes out with it
        reset <= 1'b0;
        for (int n = 0; n < NUM_INSNS; n++) begin
            random_byte(byte_val);
            len      = insn_len_table[byte_val[7:4]];
            data_in <= byte_val;
            for (int k = 1; k < len; k++) begin
                @(negedge clk);
                random_byte(byte_val);
                data_in <= byte_val;
            end
            // Decode and execute ignore the bus, it carries noise meanwhile
            repeat (2) begin
                @(negedge clk);
                random_byte(byte_val);
                data_in <= byte_val;
            end
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        assert_fails = i_cpu_ctl.i_cpu_ctl_chk.fail_count;
        $display("Summary: %0d values compared, %0d mismatches, %0d assertion failures",
                 compare_count, mismatch_count, assert_fails);
        if (mismatch_count + assert_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hw/cpu_ctl_pkg.sv
hw/insn_sequencer.sv
hw/ctl_word_gen.sv
hw/cpu_ctl.sv
verification/cpu_ctl_chk.sv
verification/cpu_ctl_scoreboard.sv
verification/cpu_ctl_tb.sv

/* Makefile */
LOG = sim.log

sim:
	verilator --binary --assert --timescale 1ns/1ps -f sim.f --top-module cpu_ctl_tb
	./obj_dir/Vcpu_ctl_tb +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
